// ==== hw/ppu_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared types, bus structs, state encodings and screen constants of the PPU
// every design file refers to them by scoped name
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package ppu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [8:0]  dot_t;        // dot or scanline number
    typedef logic [13:0] vram_addr_t;
    typedef logic [15:0] ppu_addr_t;   // full PPUADDR register
    typedef logic [5:0]  colour_t;     // NES colour index

    // register select, numbered as on the CPU bus
    typedef enum logic [2:0] {
        RS_PPUCTRL   = 3'd0,
        RS_PPUMASK   = 3'd1,
        RS_PPUSTATUS = 3'd2,
        RS_OAMADDR   = 3'd3,
        RS_OAMDATA   = 3'd4,
        RS_PPUSCROLL = 3'd5,
        RS_PPUADDR   = 3'd6,
        RS_PPUDATA   = 3'd7
    } rs_e;

    // one VRAM access, held stable by the requester while req is high
    typedef struct packed {
        vram_addr_t addr;
        logic       we;
        byte_t      wdata;
    } vram_req_t;

    typedef struct packed {
        dot_t dot;
        dot_t line;
        logic visible;
        logic dot_en;   // high in the clock where the dot advances
    } beam_t;

    typedef struct packed {
        logic [1:0] nt_select;
        logic       pattern_half;
        logic       bg_enable;
    } ctrl_view_t;

    typedef enum logic [1:0] {IDLE, ACCESS, CAPTURE, ACK} arb_state_e;

    typedef enum logic [2:0] {WAIT, NT, AT, PLO, PHI, DONE} fetch_state_e;

    localparam dot_t SCREEN_WIDTH      = 9'd341;
    localparam dot_t SCREEN_HEIGHT     = 9'd262;
    localparam dot_t VISIBLE_WIDTH     = 9'd256;
    localparam dot_t VISIBLE_HEIGHT    = 9'd240;
    localparam dot_t VBLANK_START_LINE = 9'd242;
    localparam dot_t VBLANK_END_LINE   = 9'd261;

    localparam ppu_addr_t  PALETTE_BASE     = 16'h3F00;
    localparam vram_addr_t NAMETABLE_BASE   = 14'h2000;
    localparam vram_addr_t ATTRIBUTE_OFFSET = 14'h03C0;

endpackage

`default_nettype wire

// ==== hw/ppu_timing.sv ====
////////////////////////////////////////////////////////////////////////////
// beam position: dot and scanline counters stepped once every DOT_DIV clocks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module ppu_timing #(
    parameter int DOT_DIV = 4       // clocks per dot, at least 4
) (
    input  logic            i_clk,
    input  logic            i_reset_n,
    output ppu_pkg::beam_t  o_beam
);

    localparam int CNT_W = $clog2(DOT_DIV);
    localparam logic [CNT_W-1:0] DIV_LAST = CNT_W'(DOT_DIV - 1);

    logic [CNT_W-1:0] div_cnt;
    ppu_pkg::dot_t    dot;
    ppu_pkg::dot_t    line;
    logic             dot_en;

    assign dot_en = (div_cnt == DIV_LAST);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            div_cnt <= '0;
            dot     <= '0;
            line    <= '0;
        end
        else
        begin
            div_cnt <= dot_en ? '0 : div_cnt + 1'b1;
            if (dot_en)
            begin
                if (dot == ppu_pkg::SCREEN_WIDTH - 9'd1)
                begin
                    dot  <= '0;
                    line <= (line == ppu_pkg::SCREEN_HEIGHT - 9'd1) ? '0 : line + 9'd1;
                end
                else
                begin
                    dot <= dot + 9'd1;
                end
            end
        end
    end

    assign o_beam.dot     = dot;
    assign o_beam.line    = line;
    assign o_beam.visible = (dot < ppu_pkg::VISIBLE_WIDTH) && (line < ppu_pkg::VISIBLE_HEIGHT);
    assign o_beam.dot_en  = dot_en;

endmodule

`default_nettype wire

// ==== hw/ppu_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// CPU side registers: PPUCTRL/MASK/STATUS/ADDR/DATA, vblank interrupt,
// palette RAM and the requester for CPU accesses to VRAM
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module ppu_regs (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_cs_n,
    input  ppu_pkg::rs_e         i_rs,
    input  logic                 i_rw,          // 1 read, 0 write
    input  ppu_pkg::byte_t       i_data,
    input  ppu_pkg::beam_t       i_beam,
    input  logic [4:0]           i_pal_index,
    input  logic                 i_ack,
    input  ppu_pkg::byte_t       i_rdata,
    output ppu_pkg::byte_t       o_data,
    output logic                 o_int_n,
    output logic                 o_busy,
    output logic                 o_req,
    output ppu_pkg::vram_req_t   o_vreq,
    output ppu_pkg::ctrl_view_t  o_ctrl_view,
    output ppu_pkg::colour_t     o_colour
);

    ppu_pkg::byte_t      ppuctrl;
    ppu_pkg::byte_t      ppumask;
    ppu_pkg::ppu_addr_t  ppuaddr;
    logic                addr_toggle;   // 0 = next PPUADDR write is the high byte
    logic                vblank;
    ppu_pkg::byte_t      rd_buf;
    ppu_pkg::byte_t      palette [32];
    logic                req;
    ppu_pkg::vram_req_t  vreq;

    logic wr_en;
    logic rd_en;
    logic status_rd;
    logic data_acc;
    logic is_pal;
    logic vb_start;
    logic vb_end;

    assign wr_en     = !i_cs_n && !i_rw;
    assign rd_en     = !i_cs_n && i_rw;
    assign status_rd = rd_en && (i_rs == ppu_pkg::RS_PPUSTATUS);
    assign is_pal    = (ppuaddr >= ppu_pkg::PALETTE_BASE);
    // PPUDATA access, dropped while a VRAM access is still in flight
    assign data_acc  = !i_cs_n && (i_rs == ppu_pkg::RS_PPUDATA) && !o_busy;

    assign vb_start = i_beam.dot_en && (i_beam.dot == '0)
                      && (i_beam.line == ppu_pkg::VBLANK_START_LINE);
    assign vb_end   = i_beam.dot_en && (i_beam.dot == '0)
                      && (i_beam.line == ppu_pkg::VBLANK_END_LINE);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            ppuctrl     <= '0;
            ppumask     <= '0;
            ppuaddr     <= '0;
            addr_toggle <= 1'b0;
            rd_buf      <= '0;
            req         <= 1'b0;
        end
        else
        begin
            if (wr_en && (i_rs == ppu_pkg::RS_PPUCTRL))
                ppuctrl <= i_data;
            if (wr_en && (i_rs == ppu_pkg::RS_PPUMASK))
                ppumask <= i_data;

            if (status_rd)
                addr_toggle <= 1'b0;
            else if (wr_en && (i_rs == ppu_pkg::RS_PPUADDR))
            begin
                addr_toggle <= !addr_toggle;
                if (!addr_toggle)
                    ppuaddr[15:8] <= i_data;    // high byte first
                else
                    ppuaddr[7:0] <= i_data;
            end

            if (data_acc)
                ppuaddr <= ppuaddr + (ppuctrl[2] ? 16'd32 : 16'd1);

            // four-phase request towards the arbiter
            if (data_acc && !is_pal)
                req <= 1'b1;
            else if (req && i_ack)
                req <= 1'b0;

            if (req && i_ack && !vreq.we)
                rd_buf <= i_rdata;              // refill from VRAM
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (data_acc && !is_pal)
        begin
            vreq.addr  <= ppuaddr[13:0];
            vreq.we    <= !i_rw;
            vreq.wdata <= i_data;
        end
        if (data_acc && is_pal && !i_rw)
            palette[ppuaddr[4:0]] <= i_data;
    end

    // a status read beats the end of vblank
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            vblank <= 1'b0;
        else if (status_rd)
            vblank <= 1'b0;
        else if (vb_start)
            vblank <= 1'b1;
        else if (vb_end)
            vblank <= 1'b0;
    end

    always_comb
    begin
        o_data = '0;
        if (rd_en)
        begin
            case (i_rs)
                ppu_pkg::RS_PPUSTATUS: o_data = {vblank, 7'b0};
                ppu_pkg::RS_PPUDATA:   o_data = is_pal ? palette[ppuaddr[4:0]] : rd_buf;
                default:               o_data = '0;
            endcase
        end
    end

    assign o_busy  = req | i_ack;   // ends when the ack falls
    assign o_req   = req;
    assign o_vreq  = vreq;
    assign o_int_n = !(vblank && ppuctrl[7]);

    assign o_ctrl_view.nt_select    = ppuctrl[1:0];
    assign o_ctrl_view.pattern_half = ppuctrl[4];
    assign o_ctrl_view.bg_enable    = ppumask[3];

    assign o_colour = palette[i_pal_index][5:0];

endmodule

`default_nettype wire

// ==== hw/bg_fetch.sv ====
////////////////////////////////////////////////////////////////////////////
// background tile fetcher: four VRAM reads per 8-dot slot, pattern shifters
// and the palette index of the current pixel
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module bg_fetch (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  ppu_pkg::beam_t       i_beam,
    input  ppu_pkg::ctrl_view_t  i_ctrl_view,
    input  logic                 i_ack,
    input  ppu_pkg::byte_t       i_rdata,
    output logic                 o_req,
    output ppu_pkg::vram_req_t   o_vreq,
    output logic [4:0]           o_pal_index
);

    ppu_pkg::fetch_state_e state;
    logic                  req;
    logic [4:0]            col;         // tile column being fetched
    ppu_pkg::byte_t        tile;
    logic [1:0]            attr_bits;
    ppu_pkg::byte_t        pat_lo;
    ppu_pkg::byte_t        pat_hi;
    ppu_pkg::byte_t        shift_lo;
    ppu_pkg::byte_t        shift_hi;
    logic [1:0]            attr_sh;     // attribute of the tile on screen
    ppu_pkg::vram_addr_t   nt_base;
    ppu_pkg::vram_addr_t   fetch_addr;
    logic                  start;
    logic                  fetching;
    logic                  done_rd;
    logic                  tile_end;
    logic [1:0]            pix;

    assign start    = (state == ppu_pkg::WAIT) && i_ctrl_view.bg_enable
                      && i_beam.visible && (i_beam.dot[2:0] == 3'd0);
    assign fetching = (state != ppu_pkg::WAIT) && (state != ppu_pkg::DONE);
    assign done_rd  = req && i_ack;
    assign tile_end = i_beam.dot_en && (i_beam.dot[2:0] == 3'd7);
    assign nt_base  = ppu_pkg::NAMETABLE_BASE
                      + ppu_pkg::vram_addr_t'({i_ctrl_view.nt_select, 10'b0});

    always_comb
    begin
        case (state)
            ppu_pkg::AT:  fetch_addr = nt_base + ppu_pkg::ATTRIBUTE_OFFSET
                            + ppu_pkg::vram_addr_t'({i_beam.line[7:5], col[4:2]});
            ppu_pkg::PLO: fetch_addr = {1'b0, i_ctrl_view.pattern_half, tile,
                                        1'b0, i_beam.line[2:0]};
            ppu_pkg::PHI: fetch_addr = {1'b0, i_ctrl_view.pattern_half, tile,
                                        1'b1, i_beam.line[2:0]};
            default:      fetch_addr = nt_base
                            + ppu_pkg::vram_addr_t'({i_beam.line[7:3], col});
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state <= ppu_pkg::WAIT;
            req   <= 1'b0;
        end
        else
        begin
            if (start)
                req <= 1'b1;
            else if (done_rd)
                req <= 1'b0;
            else if (fetching && !req && !i_ack)
                req <= 1'b1;                    // previous ack has fallen

            case (state)
                ppu_pkg::WAIT: if (start) state <= ppu_pkg::NT;
                ppu_pkg::NT:   if (done_rd) state <= ppu_pkg::AT;
                ppu_pkg::AT:   if (done_rd) state <= ppu_pkg::PLO;
                ppu_pkg::PLO:  if (done_rd) state <= ppu_pkg::PHI;
                ppu_pkg::PHI:  if (done_rd) state <= ppu_pkg::DONE;
                default:       if (tile_end) state <= ppu_pkg::WAIT;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (start)
            col <= i_beam.dot[7:3] + 5'd1;
        if (done_rd)
        begin
            case (state)
                ppu_pkg::NT:  tile <= i_rdata;
                ppu_pkg::AT:  attr_bits <= i_rdata[{i_beam.line[4], col[1], 1'b0} +: 2];
                ppu_pkg::PLO: pat_lo <= i_rdata;
                default:      pat_hi <= i_rdata;
            endcase
        end
    end

    // load on the tile boundary, shift one pixel per dot otherwise
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            shift_lo <= '0;
            shift_hi <= '0;
            attr_sh  <= '0;
        end
        else if (tile_end)
        begin
            shift_lo <= (state == ppu_pkg::DONE) ? pat_lo : '0;
            shift_hi <= (state == ppu_pkg::DONE) ? pat_hi : '0;
            attr_sh  <= (state == ppu_pkg::DONE) ? attr_bits : '0;
        end
        else if (i_beam.dot_en)
        begin
            shift_lo <= {shift_lo[6:0], 1'b0};
            shift_hi <= {shift_hi[6:0], 1'b0};
        end
    end

    assign pix = {shift_hi[7], shift_lo[7]};

    // first tile of a line is never fetched, so it shows entry 0
    assign o_pal_index = (i_ctrl_view.bg_enable && i_beam.visible
                          && (i_beam.dot[8:3] != '0) && (pix != 2'b00))
                         ? {1'b0, attr_sh, pix} : 5'd0;

    assign o_req  = req;
    assign o_vreq = '{addr: fetch_addr, we: 1'b0, wdata: 8'h00};

endmodule

`default_nettype wire

// ==== hw/vram_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// shares the VRAM bus between the tile fetcher and the CPU port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module vram_arbiter (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_cpu_req,
    input  ppu_pkg::vram_req_t   i_cpu_vreq,
    input  logic                 i_fetch_req,
    input  ppu_pkg::vram_req_t   i_fetch_vreq,
    input  ppu_pkg::byte_t       i_vram_data,
    output logic                 o_cpu_ack,
    output logic                 o_fetch_ack,
    output ppu_pkg::byte_t       o_rdata,
    output logic                 o_vram_rd_n,
    output logic                 o_vram_we_n,
    output ppu_pkg::vram_addr_t  o_vram_address,
    output ppu_pkg::byte_t       o_vram_data
);

    ppu_pkg::arb_state_e state;
    logic                grant_fetch;
    ppu_pkg::vram_req_t  cur;       // request of the granted side
    logic                cur_req;

    assign cur     = grant_fetch ? i_fetch_vreq : i_cpu_vreq;
    assign cur_req = grant_fetch ? i_fetch_req : i_cpu_req;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state       <= ppu_pkg::IDLE;
            grant_fetch <= 1'b1;
        end
        else
        begin
            case (state)
                ppu_pkg::IDLE:
                begin
                    if (i_fetch_req || i_cpu_req)
                    begin
                        grant_fetch <= i_fetch_req;     // fetcher first
                        state       <= ppu_pkg::ACCESS;
                    end
                end
                ppu_pkg::ACCESS:  state <= ppu_pkg::CAPTURE;
                ppu_pkg::CAPTURE: state <= ppu_pkg::ACK;
                default:          if (!cur_req) state <= ppu_pkg::IDLE;
            endcase
        end
    end

    // VRAM answers on the clock after the strobe
    always_ff @(posedge i_clk)
    begin
        if (state == ppu_pkg::CAPTURE)
            o_rdata <= i_vram_data;
    end

    assign o_vram_rd_n    = !((state == ppu_pkg::ACCESS) && !cur.we);
    assign o_vram_we_n    = !((state == ppu_pkg::ACCESS) && cur.we);
    assign o_vram_address = cur.addr;
    assign o_vram_data    = !o_vram_we_n ? cur.wdata : 8'h00;

    assign o_fetch_ack = (state == ppu_pkg::ACK) && grant_fetch;
    assign o_cpu_ack   = (state == ppu_pkg::ACK) && !grant_fetch;

endmodule

`default_nettype wire

// ==== hw/ppu_top.sv ====
////////////////////////////////////////////////////////////////////////////
// PPU top level, connects beam timing, CPU registers, fetcher and arbiter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module ppu_top #(
    parameter int DOT_DIV = 4
) (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_cs_n,
    input  ppu_pkg::rs_e         i_rs,
    input  logic                 i_rw,
    input  ppu_pkg::byte_t       i_data,
    input  ppu_pkg::byte_t       i_vram_data,
    output ppu_pkg::byte_t       o_data,
    output logic                 o_int_n,       // to the CPU NMI input
    output logic                 o_busy,
    output logic                 o_vram_rd_n,
    output logic                 o_vram_we_n,
    output ppu_pkg::vram_addr_t  o_vram_address,
    output ppu_pkg::byte_t       o_vram_data,
    output ppu_pkg::colour_t     o_colour,
    output ppu_pkg::dot_t        o_video_x,
    output ppu_pkg::dot_t        o_video_y,
    output logic                 o_video_visible
);

    ppu_pkg::beam_t       beam;
    ppu_pkg::ctrl_view_t  ctrl_view;
    logic [4:0]           pal_index;
    logic                 cpu_req;
    logic                 cpu_ack;
    logic                 fetch_req;
    logic                 fetch_ack;
    ppu_pkg::vram_req_t   cpu_vreq;
    ppu_pkg::vram_req_t   fetch_vreq;
    ppu_pkg::byte_t       rdata;        // shared by both requesters

    ppu_timing #(
        .DOT_DIV (DOT_DIV)
    ) u_timing (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .o_beam    (beam)
    );

    ppu_regs u_regs (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_cs_n      (i_cs_n),
        .i_rs        (i_rs),
        .i_rw        (i_rw),
        .i_data      (i_data),
        .i_beam      (beam),
        .i_pal_index (pal_index),
        .i_ack       (cpu_ack),
        .i_rdata     (rdata),
        .o_data      (o_data),
        .o_int_n     (o_int_n),
        .o_busy      (o_busy),
        .o_req       (cpu_req),
        .o_vreq      (cpu_vreq),
        .o_ctrl_view (ctrl_view),
        .o_colour    (o_colour)
    );

    bg_fetch u_fetch (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_beam      (beam),
        .i_ctrl_view (ctrl_view),
        .i_ack       (fetch_ack),
        .i_rdata     (rdata),
        .o_req       (fetch_req),
        .o_vreq      (fetch_vreq),
        .o_pal_index (pal_index)
    );

    vram_arbiter u_arbiter (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_cpu_req      (cpu_req),
        .i_cpu_vreq     (cpu_vreq),
        .i_fetch_req    (fetch_req),
        .i_fetch_vreq   (fetch_vreq),
        .i_vram_data    (i_vram_data),
        .o_cpu_ack      (cpu_ack),
        .o_fetch_ack    (fetch_ack),
        .o_rdata        (rdata),
        .o_vram_rd_n    (o_vram_rd_n),
        .o_vram_we_n    (o_vram_we_n),
        .o_vram_address (o_vram_address),
        .o_vram_data    (o_vram_data)
    );

    assign o_video_x       = beam.dot;
    assign o_video_y       = beam.line;
    assign o_video_visible = beam.visible;

endmodule

`default_nettype wire

// ==== tb/ppu_assert.sv ====
////////////////////////////////////////////////////////////////////////////
// handshake and strobe assertions, bound into every VRAM arbiter instance
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module ppu_assert (
    input logic i_clk,
    input logic i_reset_n,
    input logic i_cpu_req,
    input logic i_cpu_ack,
    input logic i_fetch_req,
    input logic i_fetch_ack,
    input logic i_vram_rd_n,
    input logic i_vram_we_n
);

    int fail_count = 0;     // read by the testbench at the end of the run

    cpu_ack_own: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $rose(i_cpu_ack) |-> i_cpu_req)
        else begin $error("cpu ack rose without a cpu request"); fail_count++; end

    fetch_ack_own: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $rose(i_fetch_ack) |-> i_fetch_req)
        else begin $error("fetch ack rose without a fetch request"); fail_count++; end

    // four-phase rule, a request is only withdrawn after its ack
    cpu_req_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_cpu_req && !i_cpu_ack |=> i_cpu_req)
        else begin $error("cpu request dropped before its ack"); fail_count++; end

    fetch_req_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_fetch_req && !i_fetch_ack |=> i_fetch_req)
        else begin $error("fetch request dropped before its ack"); fail_count++; end

    strobes_apart: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(!i_vram_rd_n && !i_vram_we_n))
        else begin $error("read and write strobes low together"); fail_count++; end

    rd_one_clock: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $fell(i_vram_rd_n) |=> i_vram_rd_n)
        else begin $error("read strobe longer than one clock"); fail_count++; end

    we_one_clock: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $fell(i_vram_we_n) |=> i_vram_we_n)
        else begin $error("write strobe longer than one clock"); fail_count++; end

endmodule

bind vram_arbiter ppu_assert u_assert (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_cpu_req   (i_cpu_req),
    .i_cpu_ack   (o_cpu_ack),
    .i_fetch_req (i_fetch_req),
    .i_fetch_ack (o_fetch_ack),
    .i_vram_rd_n (o_vram_rd_n),
    .i_vram_we_n (o_vram_we_n)
);

`default_nettype wire

// ==== tb/ppu_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// drives the PPU top level through directed tests against a VRAM model
// compiled with the bound arbiter assertions from the file list
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module ppu_tb;

    localparam int DOT_DIV     = 4;
    localparam int CLK_PERIOD  = 20;
    localparam int FRAME_CLKS  = 341 * 262 * DOT_DIV;
    localparam int WATCHDOG_NS = FRAME_CLKS * 3 * CLK_PERIOD;   // three frames
    localparam int NT_SEL      = 2;
    localparam int PAT_HALF    = 1;

    logic                 clk;
    logic                 reset_n;
    logic                 cs_n;
    ppu_pkg::rs_e         rs_sel;
    logic                 rw;
    ppu_pkg::byte_t       wr_data;
    ppu_pkg::byte_t       vram_data;
    ppu_pkg::byte_t       o_data;
    logic                 o_int_n;
    logic                 o_busy;
    logic                 o_vram_rd_n;
    logic                 o_vram_we_n;
    ppu_pkg::vram_addr_t  o_vram_address;
    ppu_pkg::byte_t       o_vram_data;
    ppu_pkg::colour_t     o_colour;
    ppu_pkg::dot_t        o_video_x;
    ppu_pkg::dot_t        o_video_y;
    logic                 o_video_visible;

    ppu_pkg::byte_t vram [16384];
    integer         seed = 91914;
    int             errors = 0;
    int             tests = 0;
    int             failed_tests = 0;
    int             test_start_errors = 0;
    int             fetch_reads = 0;
    logic           watch_fetch = 1'b0;

    ppu_top #(
        .DOT_DIV (DOT_DIV)
    ) u_dut (
        .i_clk           (clk),
        .i_reset_n       (reset_n),
        .i_cs_n          (cs_n),
        .i_rs            (rs_sel),
        .i_rw            (rw),
        .i_data          (wr_data),
        .i_vram_data     (vram_data),
        .o_data          (o_data),
        .o_int_n         (o_int_n),
        .o_busy          (o_busy),
        .o_vram_rd_n     (o_vram_rd_n),
        .o_vram_we_n     (o_vram_we_n),
        .o_vram_address  (o_vram_address),
        .o_vram_data     (o_vram_data),
        .o_colour        (o_colour),
        .o_video_x       (o_video_x),
        .o_video_y       (o_video_y),
        .o_video_visible (o_video_visible)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // VRAM stores on the write strobe and answers a read one clock later
    always @(posedge clk)
    begin : vram_model
        ppu_pkg::vram_addr_t addr;
        logic                rd;
        addr = o_vram_address;
        rd   = !o_vram_rd_n;
        if (!o_vram_we_n)
            vram[addr] = o_vram_data;
        #2;
        if (rd)
            vram_data = vram[addr];
    end

    // every background read in lines 37 to 40 must hit one of the fetch rules
    always @(negedge clk)
    begin : fetch_monitor
        int col;
        int base;
        int nt;
        int at;
        int plo;
        if (watch_fetch && !o_vram_rd_n && o_video_y >= 37 && o_video_y <= 40
            && o_video_x < 256)
        begin
            col  = (int'(o_video_x) / 8 + 1) % 32;     // column wraps inside the nametable
            base = 'h2000 + NT_SEL * 'h400;
            nt   = base + (int'(o_video_y) / 8) * 32 + col;
            at   = base + 'h3C0 + (int'(o_video_y) / 32) * 8 + col / 4;
            plo  = PAT_HALF * 'h1000 + int'(vram[nt]) * 16 + int'(o_video_y) % 8;
            fetch_reads++;
            assert (o_vram_address == nt || o_vram_address == at
                    || o_vram_address == plo || o_vram_address == plo + 8)
            else
            begin
                $display("error fetch_addr: expected %0h, %0h, %0h or %0h, got %0h",
                         nt, at, plo, plo + 8, o_vram_address);
                errors++;
            end
        end
    end

    task automatic check_value(input string name, input int exp, input int got);
        assert (got == exp)
        else
        begin
            $display("error %s: expected %0h, got %0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_start_errors)
            $display("test %s: ok", name);
        else
        begin
            failed_tests++;
            $display("test %s: failed", name);
        end
        test_start_errors = errors;
    endtask

    task automatic write_reg(input ppu_pkg::rs_e rs, input ppu_pkg::byte_t value);
        @(posedge clk);
        #2;
        cs_n    = 1'b0;
        rw      = 1'b0;
        rs_sel  = rs;
        wr_data = value;
        @(posedge clk);
        #2;
        cs_n = 1'b1;
    endtask

    task automatic read_reg(input ppu_pkg::rs_e rs, output ppu_pkg::byte_t value);
        @(posedge clk);
        #2;
        cs_n   = 1'b0;
        rw     = 1'b1;
        rs_sel = rs;
        @(negedge clk);
        value = o_data;     // o_data is combinational
        @(posedge clk);
        #2;
        cs_n = 1'b1;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (o_busy && n < 200)
        begin
            @(negedge clk);
            n++;
        end
        if (o_busy)
        begin
            $display("o_busy stayed high for 200 clocks after a PPUDATA access");
            errors++;
        end
    endtask

    task automatic wait_line(input int line);
        int n;
        n = 0;
        while (o_video_y != line && n < 2 * FRAME_CLKS)
        begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic data_pair(input ppu_pkg::byte_t ctrl, input ppu_pkg::byte_t d0,
                             input ppu_pkg::byte_t d1);
        write_reg(ppu_pkg::RS_PPUCTRL, ctrl);
        write_reg(ppu_pkg::RS_PPUADDR, 8'h21);
        write_reg(ppu_pkg::RS_PPUADDR, 8'h05);
        write_reg(ppu_pkg::RS_PPUDATA, d0);
        wait_idle();
        write_reg(ppu_pkg::RS_PPUDATA, d1);
        wait_idle();
    endtask

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog: the run did not finish within three frames");
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin : main
        ppu_pkg::byte_t got;
        int             n;
        cs_n      = 1'b1;
        rs_sel    = ppu_pkg::RS_PPUCTRL;
        rw        = 1'b1;
        wr_data   = '0;
        vram_data = '0;
        reset_n   = 1'b0;
        for (int a = 0; a < 16384; a++)
            vram[a] = $random(seed);
        repeat (3) @(posedge clk);
        #2;
        reset_n = 1'b1;

        @(negedge clk);
        check_value("reset_int_n", 1, o_int_n);
        check_value("reset_rd_n", 1, o_vram_rd_n);
        check_value("reset_we_n", 1, o_vram_we_n);
        check_value("reset_busy", 0, o_busy);
        end_test("reset");

        data_pair(8'h00, 8'h5A, 8'hC3);
        check_value("inc1_2105", 'h5A, vram['h2105]);
        check_value("inc1_2106", 'hC3, vram['h2106]);
        data_pair(8'h04, 8'h96, 8'h3C);     // increment by 32
        check_value("inc32_2105", 'h96, vram['h2105]);
        check_value("inc32_2125", 'h3C, vram['h2125]);
        end_test("ppudata_write");

        write_reg(ppu_pkg::RS_PPUCTRL, 8'h00);
        write_reg(ppu_pkg::RS_PPUADDR, 8'h10);
        write_reg(ppu_pkg::RS_PPUADDR, 8'h40);
        read_reg(ppu_pkg::RS_PPUDATA, got);
        check_value("read_old_buffer", 0, got);     // only writes so far
        wait_idle();
        read_reg(ppu_pkg::RS_PPUDATA, got);
        check_value("read_1040", vram['h1040], got);
        wait_idle();
        read_reg(ppu_pkg::RS_PPUDATA, got);
        check_value("read_1041", vram['h1041], got);
        wait_idle();
        end_test("buffered_read");

        write_reg(ppu_pkg::RS_PPUADDR, 8'h3F);
        write_reg(ppu_pkg::RS_PPUADDR, 8'h00);
        write_reg(ppu_pkg::RS_PPUDATA, 8'hEA);
        write_reg(ppu_pkg::RS_PPUADDR, 8'h3F);
        write_reg(ppu_pkg::RS_PPUADDR, 8'h05);
        write_reg(ppu_pkg::RS_PPUDATA, 8'h15);
        write_reg(ppu_pkg::RS_PPUADDR, 8'h3F);
        write_reg(ppu_pkg::RS_PPUADDR, 8'h00);
        read_reg(ppu_pkg::RS_PPUDATA, got);
        check_value("palette_3f00", 'hEA, got);
        write_reg(ppu_pkg::RS_PPUADDR, 8'h3F);
        write_reg(ppu_pkg::RS_PPUADDR, 8'h05);
        read_reg(ppu_pkg::RS_PPUDATA, got);
        check_value("palette_3f05", 'h15, got);
        write_reg(ppu_pkg::RS_PPUMASK, 8'h00);
        n = 0;
        for (int c = 0; c < FRAME_CLKS; c++)
        begin
            @(negedge clk);
            if (o_video_visible)
            begin
                n++;
                if (o_colour != 6'h2A)
                begin
                    check_value("backdrop_colour", 'h2A, o_colour);
                    break;
                end
            end
        end
        // one whole frame holds 256 x 240 visible dots of DOT_DIV clocks each
        if (errors == test_start_errors)
            check_value("visible_clocks", 256 * 240 * DOT_DIV, n);
        end_test("palette");

        read_reg(ppu_pkg::RS_PPUSTATUS, got);       // start from a clear flag
        write_reg(ppu_pkg::RS_PPUCTRL, 8'h80);
        n = 0;
        while (o_int_n && n < 2 * FRAME_CLKS)
        begin
            @(negedge clk);
            n++;
        end
        if (o_int_n)
        begin
            $display("o_int_n never fell while the interrupt was enabled");
            errors++;
        end
        else
            check_value("vblank_line", 242, o_video_y);
        read_reg(ppu_pkg::RS_PPUSTATUS, got);
        check_value("status_set", 1, got[7]);
        read_reg(ppu_pkg::RS_PPUSTATUS, got);
        check_value("status_clear", 0, got[7]);
        check_value("int_released", 1, o_int_n);
        end_test("vblank");

        write_reg(ppu_pkg::RS_PPUCTRL, 8'h12);      // nametable 2 with the upper pattern half
        write_reg(ppu_pkg::RS_PPUMASK, 8'h08);
        wait_line(36);
        watch_fetch = 1'b1;
        wait_line(41);
        watch_fetch = 1'b0;
        check_value("fetch_reads", 4 * 32 * 4, fetch_reads);
        end_test("fetch_addresses");

        errors += u_dut.u_arbiter.u_assert.fail_count;
        $display("%0d tests run, %0d failed, %0d assertion failures, %0d errors in total",
                 tests, failed_tests, u_dut.u_arbiter.u_assert.fail_count, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/ppu_pkg.sv
hw/ppu_timing.sv
hw/ppu_regs.sv
hw/bg_fetch.sv
hw/vram_arbiter.sv
hw/ppu_top.sv
tb/ppu_assert.sv
tb/ppu_tb.sv

// ==== Bender.yml ====
package:
  name: ppu

sources:
  - hw/ppu_pkg.sv
  - hw/ppu_timing.sv
  - hw/ppu_regs.sv
  - hw/bg_fetch.sv
  - hw/vram_arbiter.sv
  - hw/ppu_top.sv
  - target: test
    files:
      - tb/ppu_assert.sv
      - tb/ppu_tb.sv
